// ==== source/cache_geom_pkg.sv ====
// ==========================================================================
// Cache geometry package
//   ADDR_W        byte address width
//   DEF_NUM_WAY   default associativity
//   DEF_NUM_SET   default number of sets
//   DEF_BLK_BITS  default line width in bits
// ==========================================================================

package cache_geom_pkg;

  // Byte address seen by the load/store unit and the memory
  localparam int ADDR_W = 32;

  // Default associativity, must be a power of two
  localparam int DEF_NUM_WAY = 4;

  // Default set count
  localparam int DEF_NUM_SET = 16;

  // Default line width, one memory transfer per line
  localparam int DEF_BLK_BITS = 128;

endpackage

// ==== source/access_pkg.sv ====
// ==========================================================================
// CPU access package
//   size_e   load/store width encoding
//   word_t   CPU data word
// ==========================================================================

package access_pkg;

  // Access width as sent with each request
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // One CPU word
  typedef logic [31:0] word_t;

endpackage

// ==== source/way_array.sv ====
// ==========================================================================
// way_array
//   Single-port storage for one cache way
//   Registered read, write-first is not provided
//   Entry type is a parameter so tags and lines share this block
// ==========================================================================

`timescale 1ns/1ps

module way_array #(
  parameter type     entry_t = logic,
  parameter int      DEPTH   = 16,
  localparam int     IDX_W   = $clog2(DEPTH)
) (
  input  logic             clk_i,
  input  logic [IDX_W-1:0] idx_i,
  input  logic             we_i,
  input  entry_t           wdata_i,
  output entry_t           rdata_o
);

  // Storage, one entry per set
  entry_t mem_q [DEPTH];

  // Write and read on the same index
  // The read returns the old entry in a write cycle
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[idx_i] <= wdata_i;
    end
    rdata_o <= mem_q[idx_i];
  end

endmodule

// ==== source/plru_tree.sv ====
// ==========================================================================
// plru_tree
//   Tree pseudo-LRU state, NUM_WAY-1 node bits per set
//   Victim choice: lowest invalid way, else follow the tree
//   Update on use: path nodes point away from the used way
// ==========================================================================

`timescale 1ns/1ps

module plru_tree #(
  parameter int  NUM_WAY = 4,
  parameter int  NUM_SET = 16,
  localparam int IDX_W   = $clog2(NUM_SET),
  localparam int LVL     = $clog2(NUM_WAY)
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [IDX_W-1:0]   set_i,
  input  logic               use_i,
  input  logic [NUM_WAY-1:0] use_way_i,
  input  logic [NUM_WAY-1:0] valid_i,
  output logic [NUM_WAY-1:0] victim_o
);

  // Heap order: node n has children 2n+1 (left) and 2n+2 (right)
  // A set bit sends the victim search to the right
  logic [NUM_WAY-2:0] tree_q [NUM_SET];
  logic [NUM_WAY-2:0] node_bits;
  logic [NUM_WAY-2:0] next_bits;
  logic [LVL-1:0]     use_idx;
  logic [LVL-1:0]     tree_way;

  assign node_bits = tree_q[set_i];

  // Used way as an index
  always_comb begin
    use_idx = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (use_way_i[w]) begin
        use_idx = LVL'(w);
      end
    end
  end

  // Walk from the root down to a leaf
  always_comb begin
    int node;
    node = 0;
    for (int l = 0; l < LVL; l++) begin
      node = 2 * node + 1 + int'(node_bits[node]);
    end
    tree_way = LVL'(node - (NUM_WAY - 1));
  end

  // Invalid ways win, the lowest one last
  always_comb begin
    victim_o           = '0;
    victim_o[tree_way] = 1'b1;
    for (int w = NUM_WAY - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        victim_o    = '0;
        victim_o[w] = 1'b1;
      end
    end
  end

  // MSB of the way index picks the branch at the root
  always_comb begin
    int node;
    next_bits = node_bits;
    node      = 0;
    for (int l = 0; l < LVL; l++) begin
      next_bits[node] = ~use_idx[LVL-1-l];
      node            = 2 * node + 1 + int'(use_idx[LVL-1-l]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SET; s++) begin
        tree_q[s] <= '0;
      end
    end else if (use_i) begin
      tree_q[set_i] <= next_bits;
    end
  end

endmodule

// ==== source/store_merge.sv ====
// ==========================================================================
// store_merge
//   Byte, half or word store into a cache line
//   Aligned load word taken from the merged line
// ==========================================================================

`timescale 1ns/1ps

module store_merge #(
  parameter int  BLK_BITS = 128,
  localparam int OFF_W    = $clog2(BLK_BITS / 8)
) (
  input  logic [BLK_BITS-1:0] line_i,
  input  logic [OFF_W-1:0]    offset_i,
  input  access_pkg::size_e   size_i,
  input  logic                we_i,
  input  access_pkg::word_t   wdata_i,
  output logic [BLK_BITS-1:0] line_o,
  output access_pkg::word_t   word_o
);

  import access_pkg::*;

  always_comb begin
    int byte_pos;
    int half_pos;
    int word_pos;
    // Bit positions of the addressed byte, half and word
    byte_pos = 8 * int'(offset_i);
    half_pos = 16 * int'(offset_i >> 1);
    word_pos = 32 * int'(offset_i >> 2);

    line_o = line_i;
    if (we_i) begin
      case (size_i)
        SIZE_BYTE: line_o[byte_pos +: 8]  = wdata_i[7:0];
        SIZE_HALF: line_o[half_pos +: 16] = wdata_i[15:0];
        // Unused encoding falls back to a full word
        default:   line_o[word_pos +: 32] = wdata_i;
      endcase
    end

    // Response word, already holding any store data
    word_o = line_o[word_pos +: 32];
  end

endmodule

// ==== source/dcache_ctrl.sv ====
// ==========================================================================
// dcache_ctrl
//   Access FSM: IDLE, LOOKUP, WRITEBACK, FILL, RESPOND
//   Per-set valid and dirty registers
//   Tag compare, array write enables and memory requests
// ==========================================================================

`timescale 1ns/1ps

module dcache_ctrl #(
  parameter int  NUM_WAY  = cache_geom_pkg::DEF_NUM_WAY,
  parameter int  NUM_SET  = cache_geom_pkg::DEF_NUM_SET,
  parameter int  BLK_BITS = cache_geom_pkg::DEF_BLK_BITS,
  localparam int OFF_W    = $clog2(BLK_BITS / 8),
  localparam int IDX_W    = $clog2(NUM_SET),
  localparam int TAG_W    = cache_geom_pkg::ADDR_W - IDX_W - OFF_W
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // CPU side
  input  logic                              req_valid_i,
  input  logic                              req_we_i,
  input  access_pkg::size_e                 req_size_i,
  input  logic [cache_geom_pkg::ADDR_W-1:0] req_addr_i,
  input  access_pkg::word_t                 req_wdata_i,
  output logic                              req_ready_o,
  output logic                              rsp_valid_o,
  output access_pkg::word_t                 rsp_rdata_o,
  // Memory side
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [cache_geom_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [BLK_BITS-1:0]               mem_wdata_o,
  input  logic                              mem_ack_i,
  input  logic [BLK_BITS-1:0]               mem_rdata_i,
  // Tag and data arrays
  output logic [IDX_W-1:0]                  arr_idx_o,
  output logic [NUM_WAY-1:0]                tag_we_o,
  output logic [TAG_W-1:0]                  tag_wdata_o,
  output logic [NUM_WAY-1:0]                data_we_o,
  output logic [BLK_BITS-1:0]               data_wdata_o,
  input  logic [NUM_WAY-1:0][TAG_W-1:0]     tags_i,
  input  logic [NUM_WAY-1:0][BLK_BITS-1:0]  lines_i,
  // Replacement
  output logic                              plru_use_o,
  output logic [NUM_WAY-1:0]                plru_way_o,
  output logic [NUM_WAY-1:0]                valid_o,
  input  logic [NUM_WAY-1:0]                victim_i,
  // Store merge
  output logic [OFF_W-1:0]                  merge_offset_o,
  output access_pkg::size_e                 merge_size_o,
  output logic                              merge_we_o,
  output access_pkg::word_t                 merge_wdata_o,
  output logic [BLK_BITS-1:0]               merge_line_o,
  input  logic [BLK_BITS-1:0]               merge_line_i,
  input  access_pkg::word_t                 merge_word_i
);

  import cache_geom_pkg::*;
  import access_pkg::*;

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, FILL, RESPOND} state_e;

  state_e              state_q;
  logic                mem_req_q;
  // Accepted request
  logic                req_we_q;
  size_e               req_size_q;
  logic [ADDR_W-1:0]   req_addr_q;
  word_t               req_wdata_q;
  logic [IDX_W-1:0]    idx_q;
  logic [TAG_W-1:0]    tag_q;
  // Hit way, or the victim on a miss
  logic [NUM_WAY-1:0]  way_q;
  word_t               rdata_q;
  logic [NUM_WAY-1:0]  valid_q [NUM_SET];
  logic [NUM_WAY-1:0]  dirty_q [NUM_SET];
  logic [NUM_WAY-1:0]  set_valid;
  logic [NUM_WAY-1:0]  set_dirty;
  logic [NUM_WAY-1:0]  hit_vec;
  logic [BLK_BITS-1:0] hit_line;
  logic [BLK_BITS-1:0] way_line;
  logic [TAG_W-1:0]    way_tag;
  logic                accept;
  logic                hit;
  logic                hit_store;
  logic                fill_done;

  assign idx_q     = req_addr_q[OFF_W +: IDX_W];
  assign tag_q     = req_addr_q[ADDR_W-1 -: TAG_W];
  assign set_valid = valid_q[idx_q];
  assign set_dirty = dirty_q[idx_q];
  assign accept    = req_valid_i && req_ready_o;

  // Tag compare and way muxes
  always_comb begin
    hit_line = '0;
    way_line = '0;
    way_tag  = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_vec[w] = set_valid[w] && (tags_i[w] == tag_q);
      if (hit_vec[w]) begin
        hit_line = lines_i[w];
      end
      if (way_q[w]) begin
        way_line = lines_i[w];
        way_tag  = tags_i[w];
      end
    end
  end

  assign hit       = |hit_vec;
  assign hit_store = (state_q == LOOKUP) && hit && req_we_q;
  // Fill data arrives with the ack, the line is written in that cycle
  assign fill_done = (state_q == FILL) && mem_req_q && mem_ack_i;

  // ========================================================================
  // Request and response registers
  // ========================================================================
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_we_q    <= req_we_i;
      req_size_q  <= req_size_i;
      req_addr_q  <= req_addr_i;
      req_wdata_q <= req_wdata_i;
    end
    if (state_q == LOOKUP) begin
      way_q   <= hit ? hit_vec : victim_i;
      rdata_q <= merge_word_i;
    end else if (fill_done) begin
      rdata_q <= merge_word_i;
    end
  end

  // ========================================================================
  // FSM
  // ========================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      mem_req_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (hit) begin
            state_q <= RESPOND;
          end else begin
            mem_req_q <= 1'b1;
            // Dirty valid victim goes out before the fill
            if (|(victim_i & set_valid & set_dirty)) begin
              state_q <= WRITEBACK;
            end else begin
              state_q <= FILL;
            end
          end
        end
        WRITEBACK: begin
          if (mem_ack_i) begin
            mem_req_q <= 1'b0;
            state_q   <= FILL;
          end
        end
        FILL: begin
          // One idle cycle after a write-back ack
          if (!mem_req_q) begin
            mem_req_q <= 1'b1;
          end else if (mem_ack_i) begin
            mem_req_q <= 1'b0;
            state_q   <= RESPOND;
          end
        end
        RESPOND: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Valid and dirty bits
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SET; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else if (fill_done) begin
      valid_q[idx_q] <= set_valid | way_q;
      dirty_q[idx_q] <= req_we_q ? (set_dirty | way_q) : (set_dirty & ~way_q);
    end else if (hit_store) begin
      dirty_q[idx_q] <= set_dirty | hit_vec;
    end
  end

  // Arrays read the incoming index while idle
  assign arr_idx_o    = (state_q == IDLE) ? req_addr_i[OFF_W +: IDX_W] : idx_q;
  assign tag_we_o     = fill_done ? way_q : '0;
  assign tag_wdata_o  = tag_q;
  assign data_we_o    = fill_done ? way_q : (hit_store ? hit_vec : '0);
  assign data_wdata_o = merge_line_i;

  // Merge source is the hit line or the fill data
  assign merge_line_o   = (state_q == FILL) ? mem_rdata_i : hit_line;
  assign merge_offset_o = req_addr_q[OFF_W-1:0];
  assign merge_size_o   = req_size_q;
  assign merge_we_o     = req_we_q;
  assign merge_wdata_o  = req_wdata_q;

  // Write-back address rebuilt from the victim tag
  assign mem_req_o   = mem_req_q;
  assign mem_we_o    = (state_q == WRITEBACK);
  assign mem_addr_o  = (state_q == WRITEBACK) ? {way_tag, idx_q, {OFF_W{1'b0}}}
                                              : {tag_q, idx_q, {OFF_W{1'b0}}};
  assign mem_wdata_o = way_line;

  assign plru_use_o = (state_q == RESPOND);
  assign plru_way_o = way_q;
  assign valid_o    = set_valid;

  assign req_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == RESPOND);
  assign rsp_rdata_o = rdata_q;

endmodule

// ==== source/dcache_top.sv ====
// ==========================================================================
// dcache_top
//   Set-associative write-back data cache
//   Per-way tag and data arrays, PLRU, store merge and controller
// ==========================================================================

`timescale 1ns/1ps

module dcache_top #(
  parameter int NUM_WAY  = cache_geom_pkg::DEF_NUM_WAY,
  parameter int NUM_SET  = cache_geom_pkg::DEF_NUM_SET,
  parameter int BLK_BITS = cache_geom_pkg::DEF_BLK_BITS
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_valid_i,
  input  logic                              req_we_i,
  input  access_pkg::size_e                 req_size_i,
  input  logic [cache_geom_pkg::ADDR_W-1:0] req_addr_i,
  input  access_pkg::word_t                 req_wdata_i,
  output logic                              req_ready_o,
  output logic                              rsp_valid_o,
  output access_pkg::word_t                 rsp_rdata_o,
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [cache_geom_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [BLK_BITS-1:0]               mem_wdata_o,
  input  logic                              mem_ack_i,
  input  logic [BLK_BITS-1:0]               mem_rdata_i
);

  import cache_geom_pkg::*;
  import access_pkg::*;

  localparam int OFF_W = $clog2(BLK_BITS / 8);
  localparam int IDX_W = $clog2(NUM_SET);
  localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

  logic [IDX_W-1:0]                 arr_idx;
  logic [NUM_WAY-1:0]               tag_we;
  logic [TAG_W-1:0]                 tag_wdata;
  logic [NUM_WAY-1:0]               data_we;
  logic [BLK_BITS-1:0]              data_wdata;
  logic [NUM_WAY-1:0][TAG_W-1:0]    tags;
  logic [NUM_WAY-1:0][BLK_BITS-1:0] lines;
  logic                             plru_use;
  logic [NUM_WAY-1:0]               plru_way;
  logic [NUM_WAY-1:0]               set_valid;
  logic [NUM_WAY-1:0]               victim;
  logic [OFF_W-1:0]                 merge_offset;
  size_e                            merge_size;
  logic                             merge_we;
  word_t                            merge_wdata;
  logic [BLK_BITS-1:0]              merge_src;
  logic [BLK_BITS-1:0]              merge_line;
  word_t                            merge_word;

  // One tag array and one data array per way
  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    way_array #(
      .entry_t (logic [TAG_W-1:0]),
      .DEPTH   (NUM_SET)
    ) u_tag (
      .clk_i   (clk_i),
      .idx_i   (arr_idx),
      .we_i    (tag_we[w]),
      .wdata_i (tag_wdata),
      .rdata_o (tags[w])
    );
    way_array #(
      .entry_t (logic [BLK_BITS-1:0]),
      .DEPTH   (NUM_SET)
    ) u_data (
      .clk_i   (clk_i),
      .idx_i   (arr_idx),
      .we_i    (data_we[w]),
      .wdata_i (data_wdata),
      .rdata_o (lines[w])
    );
  end

  plru_tree #(
    .NUM_WAY   (NUM_WAY),
    .NUM_SET   (NUM_SET)
  ) u_plru (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .set_i     (arr_idx),
    .use_i     (plru_use),
    .use_way_i (plru_way),
    .valid_i   (set_valid),
    .victim_o  (victim)
  );

  store_merge #(
    .BLK_BITS (BLK_BITS)
  ) u_merge (
    .line_i   (merge_src),
    .offset_i (merge_offset),
    .size_i   (merge_size),
    .we_i     (merge_we),
    .wdata_i  (merge_wdata),
    .line_o   (merge_line),
    .word_o   (merge_word)
  );

  // CPU and memory ports share their names with the top
  dcache_ctrl #(
    .NUM_WAY        (NUM_WAY),
    .NUM_SET        (NUM_SET),
    .BLK_BITS       (BLK_BITS)
  ) u_ctrl (
    .*,
    .arr_idx_o      (arr_idx),
    .tag_we_o       (tag_we),
    .tag_wdata_o    (tag_wdata),
    .data_we_o      (data_we),
    .data_wdata_o   (data_wdata),
    .tags_i         (tags),
    .lines_i        (lines),
    .plru_use_o     (plru_use),
    .plru_way_o     (plru_way),
    .valid_o        (set_valid),
    .victim_i       (victim),
    .merge_offset_o (merge_offset),
    .merge_size_o   (merge_size),
    .merge_we_o     (merge_we),
    .merge_wdata_o  (merge_wdata),
    .merge_line_o   (merge_src),
    .merge_line_i   (merge_line),
    .merge_word_i   (merge_word)
  );

endmodule

// ==== sim/dcache_tb.sv ====
// ==========================================================================
// Directed testbench for dcache_top
//   Line-wide memory model with random ack delay and a request log
//   Byte-level reference memory that predicts every response
//   Tests for read miss and hit, sub-word stores, dirty write-back,
//   PLRU victim and a random mix
// ==========================================================================

`timescale 1ns/1ps

module dcache_tb;

  import cache_geom_pkg::*;
  import access_pkg::*;

  localparam int BLK_BITS   = DEF_BLK_BITS;
  localparam int OFF_W      = $clog2(BLK_BITS / 8);
  localparam int IDX_W      = $clog2(DEF_NUM_SET);
  localparam int WPL        = BLK_BITS / 32;
  localparam int WAIT_LIMIT = 200;

  logic                clk_i;
  logic                rst_ni;
  logic                req_valid_i;
  logic                req_we_i;
  size_e               req_size_i;
  logic [ADDR_W-1:0]   req_addr_i;
  word_t               req_wdata_i;
  logic                req_ready_o;
  logic                rsp_valid_o;
  word_t               rsp_rdata_o;
  logic                mem_req_o;
  logic                mem_we_o;
  logic [ADDR_W-1:0]   mem_addr_o;
  logic [BLK_BITS-1:0] mem_wdata_o;
  logic                mem_ack_i;
  logic [BLK_BITS-1:0] mem_rdata_i;

  int seed = 32'h24d9_e9af;
  int errors;
  int checks;
  int req_count;

  // Backing lines written by the cache and keyed by line address
  logic [BLK_BITS-1:0] mem_lines [logic [ADDR_W-1:0]];
  // Bytes stored by the CPU
  // Bytes never stored follow the fill pattern
  logic [7:0]          ref_mem [logic [ADDR_W-1:0]];
  // Every memory request in issue order
  logic                log_we [$];
  logic [ADDR_W-1:0]   log_addr [$];
  logic [BLK_BITS-1:0] log_data [$];

  dcache_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ========================================================================
  // Address helpers and reference memory
  // ========================================================================
  function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int off);
    return (tag << (OFF_W + IDX_W)) | (set << OFF_W) | off;
  endfunction

  // Initial memory content depends on the full word address
  function automatic word_t pattern_word(input logic [ADDR_W-1:0] a);
    return (a * 32'h9e37_79b9) ^ 32'h6a09_e667;
  endfunction

  function automatic logic [BLK_BITS-1:0] line_read(input logic [ADDR_W-1:0] la);
    logic [BLK_BITS-1:0] line;
    if (mem_lines.exists(la)) begin
      return mem_lines[la];
    end
    for (int i = 0; i < WPL; i++) begin
      line[32*i +: 32] = pattern_word(la + 4 * i);
    end
    return line;
  endfunction

  function automatic logic [7:0] ref_byte(input logic [ADDR_W-1:0] a);
    word_t w;
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    w = pattern_word({a[ADDR_W-1:2], 2'b00});
    return w[8 * a[1:0] +: 8];
  endfunction

  // Aligned word holding the address
  function automatic word_t ref_word(input logic [ADDR_W-1:0] a);
    word_t w;
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = ref_byte({a[ADDR_W-1:2], 2'b00} + b);
    end
    return w;
  endfunction

  // Halves and words are naturally aligned
  // Only the low wdata bits are stored
  task automatic ref_store(input size_e size, input logic [ADDR_W-1:0] a, input word_t wdata);
    case (size)
      SIZE_BYTE: ref_mem[a] = wdata[7:0];
      SIZE_HALF: begin
        for (int b = 0; b < 2; b++) begin
          ref_mem[{a[ADDR_W-1:1], 1'b0} + b] = wdata[8*b +: 8];
        end
      end
      default: begin
        for (int b = 0; b < 4; b++) begin
          ref_mem[{a[ADDR_W-1:2], 2'b00} + b] = wdata[8*b +: 8];
        end
      end
    endcase
  endtask

  // ========================================================================
  // Memory model
  // ========================================================================
  initial begin : memory_model
    logic [31:0]         r;
    logic                we;
    logic [ADDR_W-1:0]   addr;
    logic [BLK_BITS-1:0] wdata;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (mem_req_o === 1'b1) begin
        we    = mem_we_o;
        addr  = mem_addr_o;
        wdata = mem_wdata_o;
        req_count++;
        log_we.push_back(we);
        log_addr.push_back(addr);
        log_data.push_back(wdata);
        // Ack after 1 to 4 cycles
        r = $random(seed);
        repeat (1 + int'(r[1:0])) @(posedge clk_i);
        #1;
        mem_ack_i   = 1'b1;
        mem_rdata_i = we ? '0 : line_read(addr);
        @(posedge clk_i);
        if (we) begin
          mem_lines[addr] = wdata;
        end
        #1;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
      end
    end
  end

  // ========================================================================
  // Checks and access tasks
  // ========================================================================
  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("Errors found");
    $finish;
  endtask

  // One request that returns the response word and the cycles from acceptance
  task automatic do_access(input logic we, input size_e size, input logic [ADDR_W-1:0] addr,
                           input word_t wdata, output word_t rdata, output int lat);
    int waited;
    waited = 0;
    while (!req_ready_o) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("req_ready_o stayed low");
      end
    end
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_size_i  = size;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    lat         = 1;
    while (!rsp_valid_o) begin
      check_flag("req_ready_o while busy", req_ready_o, 1'b0);
      @(posedge clk_i);
      #1;
      lat++;
      if (lat > WAIT_LIMIT) begin
        abort_run("no rsp_valid_o pulse after the request");
      end
    end
    check_flag("req_ready_o during response", req_ready_o, 1'b0);
    rdata = rsp_rdata_o;
    // Response is a single-cycle pulse and the cache is ready right after it
    @(posedge clk_i);
    #1;
    check_flag("rsp_valid_o after response", rsp_valid_o, 1'b0);
    check_flag("req_ready_o after response", req_ready_o, 1'b1);
  endtask

  // Access with the response checked against the reference memory
  task automatic checked_access(input logic we, input size_e size,
                                input logic [ADDR_W-1:0] addr, input word_t wdata,
                                output int reqs, output int lat);
    int    n0;
    word_t rdata;
    n0 = req_count;
    do_access(we, size, addr, wdata, rdata, lat);
    reqs = req_count - n0;
    if (we) begin
      ref_store(size, addr, wdata);
    end
    check_word("rsp_rdata_o", rdata, ref_word(addr));
  endtask

  task automatic report_test(input string name, input int e0);
    $display("%s: %0d errors", name, errors - e0);
  endtask

  // ========================================================================
  // Tests
  // ========================================================================
  task automatic test_read_miss_hit();
    int                e0;
    int                reqs;
    int                lat;
    logic [ADDR_W-1:0] a;
    e0 = errors;
    a  = make_addr(32'h10, 2, 4);
    checked_access(1'b0, SIZE_WORD, a, '0, reqs, lat);
    check_count("memory requests on miss", reqs, 1);
    check_count("mem_we_o on miss", int'(log_we[log_we.size() - 1]), 0);
    checked_access(1'b0, SIZE_WORD, a + 8, '0, reqs, lat);
    check_count("memory requests on hit", reqs, 0);
    check_count("hit latency", lat, 2);
    report_test("read miss then hit", e0);
  endtask

  task automatic test_sub_word_stores();
    int                e0;
    int                reqs;
    int                lat;
    logic [ADDR_W-1:0] a;
    e0 = errors;
    a  = make_addr(32'h20, 5, 0);
    checked_access(1'b1, SIZE_BYTE, a + 1, 32'h0000_00ab, reqs, lat);
    checked_access(1'b1, SIZE_HALF, a + 6, 32'h7777_c3d4, reqs, lat);
    checked_access(1'b1, SIZE_WORD, a + 12, 32'h1234_5678, reqs, lat);
    for (int i = 0; i < WPL; i++) begin
      checked_access(1'b0, SIZE_WORD, a + 4 * i, '0, reqs, lat);
    end
    report_test("sub-word stores", e0);
  endtask

  task automatic test_dirty_writeback();
    int                e0;
    int                reqs;
    int                lat;
    int                total;
    int                start;
    int                wb;
    logic [ADDR_W-1:0] a;
    e0    = errors;
    a     = make_addr(32'h30, 7, 0);
    total = 0;
    checked_access(1'b1, SIZE_WORD, a + 8, 32'hdead_beef, reqs, lat);
    start = log_we.size();
    // Four clean tags where the last one evicts the dirty line in way 0
    for (int t = 1; t <= 4; t++) begin
      checked_access(1'b0, SIZE_WORD, make_addr(32'h30 + t, 7, 0), '0, reqs, lat);
      total += reqs;
    end
    check_count("memory requests for four fills", total, 5);
    wb = -1;
    for (int i = start; i < log_we.size(); i++) begin
      if (log_we[i] && wb < 0) begin
        wb = i;
      end
    end
    if (wb < 0) begin
      errors++;
      $display("Eviction of the dirty line issued no write-back request");
    end else begin
      check_addr("mem_addr_o on write-back", log_addr[wb], a);
      check_word("mem_wdata_o word 2", log_data[wb][95:64], ref_word(a + 8));
      if (wb + 1 >= log_we.size() || log_we[wb + 1]) begin
        errors++;
        $display("Write-back was not followed by a fill read");
      end else begin
        check_addr("mem_addr_o on fill", log_addr[wb + 1], make_addr(32'h34, 7, 0));
      end
    end
    checked_access(1'b0, SIZE_WORD, a + 8, '0, reqs, lat);
    check_count("memory requests on reload", reqs, 1);
    report_test("dirty write-back", e0);
  endtask

  task automatic test_plru_victim();
    int e0;
    int reqs;
    int lat;
    int order [3];
    e0 = errors;
    for (int t = 0; t < 4; t++) begin
      checked_access(1'b0, SIZE_WORD, make_addr(32'h40 + t, 9, 0), '0, reqs, lat);
    end
    // Way 1 used last sends the root right
    // Way 2 used before it leaves way 3 as the victim
    order = '{2, 0, 1};
    for (int i = 0; i < 3; i++) begin
      checked_access(1'b0, SIZE_WORD, make_addr(32'h40 + order[i], 9, 4), '0, reqs, lat);
      check_count("memory requests on re-read", reqs, 0);
    end
    checked_access(1'b0, SIZE_WORD, make_addr(32'h44, 9, 0), '0, reqs, lat);
    check_count("memory requests for new tag", reqs, 1);
    for (int t = 0; t < 3; t++) begin
      checked_access(1'b0, SIZE_WORD, make_addr(32'h40 + t, 9, 8), '0, reqs, lat);
      check_count("memory requests on kept way", reqs, 0);
    end
    checked_access(1'b0, SIZE_WORD, make_addr(32'h43, 9, 8), '0, reqs, lat);
    check_count("memory requests on evicted way", reqs, 1);
    report_test("PLRU victim", e0);
  endtask

  task automatic test_random_mix();
    int          e0;
    int          reqs;
    int          lat;
    int          off;
    int          set;
    int          sets [3];
    logic [31:0] r;
    size_e       size;
    word_t       wdata;
    e0   = errors;
    sets = '{1, 3, 11};
    for (int n = 0; n < 200; n++) begin
      r     = $random(seed);
      wdata = $random(seed);
      size  = (r[2:1] == 2'd0) ? SIZE_BYTE : ((r[2:1] == 2'd1) ? SIZE_HALF : SIZE_WORD);
      set   = sets[int'(r[4:3]) % 3];
      off   = int'(r[11:8]);
      if (size == SIZE_HALF) begin
        off = off - (off % 2);
      end else if (size == SIZE_WORD) begin
        off = off - (off % 4);
      end
      checked_access(r[0], size, make_addr(32'h50 + int'(r[7:5]), set, off), wdata, reqs, lat);
    end
    report_test("random mix", e0);
  endtask

  // ========================================================================
  // Main sequence
  // ========================================================================
  initial begin
    errors      = 0;
    checks      = 0;
    req_count   = 0;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_size_i  = SIZE_WORD;
    req_addr_i  = '0;
    req_wdata_i = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Idle outputs right after reset
    check_flag("req_ready_o after reset", req_ready_o, 1'b1);
    check_flag("rsp_valid_o after reset", rsp_valid_o, 1'b0);
    check_flag("mem_req_o after reset", mem_req_o, 1'b0);
    test_read_miss_hit();
    test_sub_word_stores();
    test_dirty_writeback();
    test_plru_victim();
    test_random_mix();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/cache_geom_pkg.sv
source/access_pkg.sv
source/way_array.sv
source/plru_tree.sv
source/store_merge.sv
source/dcache_ctrl.sv
source/dcache_top.sv
sim/dcache_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = dcache_tb
FILELIST = vlog.f
LOG      = sim.log
PASS_MSG = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
